// File: list.f
rtl/mmu_pkg.sv
rtl/mmu_csr.sv
rtl/tlb_array.sv
rtl/addr_trans.sv
rtl/mmu_top.sv
testbench/mmu_assert.sv
testbench/tb_mmu.sv

// File: rtl/addr_trans.sv
`timescale 1ns/100ps

module addr_trans import mmu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush_i,
    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  mem_req_t    req_i,
    output logic        rsp_valid_o,
    input  logic        rsp_ready_i,
    output mem_rsp_t    rsp_o,
    input  trans_ctx_t  ctx_i,
    input  logic        hold_i,
    output vppn_t       srch_vppn_o,
    output logic        srch_odd_o,
    output asid_t       srch_asid_o,
    input  tlb_lookup_t lookup_i
);

    logic      s1_valid;
    mem_req_t  s1_req;
    logic      s1_misalign;
    logic      s1_fire;
    logic      s2_valid;
    mem_req_t  s2_req;
    logic      s2_misalign;
    logic      s2_fire;
    logic      s2_free;
    mem_rsp_t  s2_rsp;
    logic      out_valid;
    mem_rsp_t  out_rsp;
    vaddr_t    va;
    logic      dmw0_hit;
    logic      dmw1_hit;
    logic      use_tlb;
    tlb_page_t page;

    function automatic logic dmw_match(csr_data_t dmw, vaddr_t addr, plv_t plv);
        return (dmw[DMW_VSEG_LSB +: 3] == addr[31:29])
               && ((dmw[DMW_PLV0_BIT] && plv == 2'd0) || (dmw[DMW_PLV3_BIT] && plv == 2'd3));
    endfunction

    // ready chain from the output register back to the request port
    assign s2_fire     = s2_valid && !hold_i && (!out_valid || rsp_ready_i);
    assign s2_free     = !s2_valid || s2_fire;
    assign s1_fire     = s1_valid && s2_free;
    assign req_ready_o = (!s1_valid || s1_fire) && !flush_i;

    // stage 1 does the alignment check
    always_comb begin
        case (s1_req.size)
            HALF:    s1_misalign = s1_req.vaddr[0];
            WORD:    s1_misalign = |s1_req.vaddr[1:0];
            default: s1_misalign = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (req_ready_o) begin
                s1_valid <= req_valid_i;
            end
            if (s2_free) begin
                s2_valid <= s1_valid;
            end
            if (!out_valid || rsp_ready_i) begin
                out_valid <= s2_fire;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready_o && req_valid_i) begin
            s1_req <= req_i;
        end
        if (s1_fire) begin
            s2_req      <= s1_req;
            s2_misalign <= s1_misalign;
        end
        if (s2_fire) begin
            out_rsp <= s2_rsp;
        end
    end

    // stage 2 window match, DMW0 first
    assign va       = s2_req.vaddr;
    assign page     = lookup_i.page;
    assign dmw0_hit = !ctx_i.direct && dmw_match(ctx_i.dmw0, va, ctx_i.plv);
    assign dmw1_hit = !ctx_i.direct && !dmw0_hit && dmw_match(ctx_i.dmw1, va, ctx_i.plv);
    assign use_tlb  = !ctx_i.direct && !dmw0_hit && !dmw1_hit;

    assign srch_vppn_o = va[31:13];
    assign srch_odd_o  = va[12];
    assign srch_asid_o = ctx_i.asid;

    always_comb begin
        if (dmw0_hit) begin
            s2_rsp.paddr    = {ctx_i.dmw0[DMW_PSEG_LSB +: 3], va[28:0]};
            s2_rsp.uncached = mat_t'(ctx_i.dmw0[DMW_MAT_LSB +: 2]) == '0;
        end else if (dmw1_hit) begin
            s2_rsp.paddr    = {ctx_i.dmw1[DMW_PSEG_LSB +: 3], va[28:0]};
            s2_rsp.uncached = mat_t'(ctx_i.dmw1[DMW_MAT_LSB +: 2]) == '0;
        end else if (use_tlb) begin
            if (lookup_i.ps == PS_4K) begin
                s2_rsp.paddr = {page.ppn, va[11:0]};
            end else begin
                s2_rsp.paddr = {page.ppn[19:9], va[20:0]};
            end
            s2_rsp.uncached = page.mat == '0;
        end else begin
            // direct mode
            s2_rsp.paddr    = va;
            s2_rsp.uncached = 1'b0;
        end

        // highest priority first
        if (ctx_i.plv == 2'd3 && va[31] && use_tlb) begin
            s2_rsp.excp = EXC_ADEM;
        end else if (s2_misalign) begin
            s2_rsp.excp = EXC_ALE;
        end else if (use_tlb && !lookup_i.found) begin
            s2_rsp.excp = EXC_TLBR;
        end else if (use_tlb && !page.valid) begin
            s2_rsp.excp = s2_req.is_store ? EXC_PIS : EXC_PIL;
        end else if (use_tlb && ctx_i.plv > page.plv) begin
            s2_rsp.excp = EXC_PPI;
        end else if (use_tlb && s2_req.is_store && !page.dirty) begin
            s2_rsp.excp = EXC_PME;
        end else begin
            s2_rsp.excp = EXC_NONE;
        end
    end

    assign rsp_valid_o = out_valid;
    assign rsp_o       = out_rsp;

endmodule

// File: rtl/mmu_csr.sv
`timescale 1ns/100ps

module mmu_csr import mmu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  csr_wr_t     csr_wr_i,
    input  csr_addr_t   csr_raddr_i,
    output csr_data_t   csr_rdata_o,
    input  tlb_cmd_t    tlb_cmd_i,
    input  tlb_lookup_t lookup_i,
    output trans_ctx_t  ctx_o,
    output logic        tlb_we_o,
    output tlb_idx_t    tlb_widx_o,
    output tlb_entry_t  tlb_wentry_o,
    output logic        srch_sel_o,
    output vppn_t       srch_vppn_o,
    output logic        inv_all_o,
    output logic        inv_match_o,
    output asid_t       inv_asid_o,
    output vppn_t       inv_vppn_o
);

    logic      crmd_da;
    plv_t      crmd_plv;
    asid_t     asid_q;
    csr_data_t dmw0_q;
    csr_data_t dmw1_q;
    tlb_idx_t  idx_q;
    ps_t       idx_ps;
    logic      idx_ne;
    vppn_t     ehi_vppn;
    tlb_page_t elo0_q;
    tlb_page_t elo1_q;
    logic      elo0_g;
    logic      elo1_g;
    tlb_idx_t  fill_ptr;
    tlb_op_e   op;
    csr_data_t wdata;

    function automatic tlb_page_t elo_page(csr_data_t d);
        tlb_page_t p;
        p.valid = d[ELO_V_BIT];
        p.dirty = d[ELO_D_BIT];
        p.plv   = d[ELO_PLV_LSB +: 2];
        p.mat   = d[ELO_MAT_LSB +: 2];
        p.ppn   = d[ELO_PPN_LSB +: 20];
        return p;
    endfunction

    function automatic csr_data_t elo_word(tlb_page_t p, logic g);
        csr_data_t d;
        d = '0;
        d[ELO_V_BIT]          = p.valid;
        d[ELO_D_BIT]          = p.dirty;
        d[ELO_PLV_LSB +: 2]   = p.plv;
        d[ELO_MAT_LSB +: 2]   = p.mat;
        d[ELO_G_BIT]          = g;
        d[ELO_PPN_LSB +: 20]  = p.ppn;
        return d;
    endfunction

    assign op    = tlb_cmd_i.op;
    assign wdata = csr_wr_i.wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            // boot in direct mode at PLV0
            crmd_da  <= 1'b1;
            crmd_plv <= '0;
            asid_q   <= '0;
            dmw0_q   <= '0;
            dmw1_q   <= '0;
            idx_q    <= '0;
            idx_ps   <= '0;
            idx_ne   <= 1'b0;
            ehi_vppn <= '0;
            elo0_q   <= '0;
            elo1_q   <= '0;
            elo0_g   <= 1'b0;
            elo1_g   <= 1'b0;
            fill_ptr <= '0;
        end else begin
            if (csr_wr_i.we) begin
                case (csr_wr_i.addr)
                    CSR_CRMD: begin
                        crmd_da  <= wdata[CRMD_DA_BIT];
                        crmd_plv <= wdata[CRMD_PLV_LSB +: 2];
                    end
                    CSR_ASID: asid_q <= wdata[9:0];
                    CSR_DMW0: dmw0_q <= wdata;
                    CSR_DMW1: dmw1_q <= wdata;
                    CSR_TLBIDX: begin
                        idx_q  <= wdata[TLBIDX_IDX_LSB +: 4];
                        idx_ps <= wdata[TLBIDX_PS_LSB +: 6];
                        idx_ne <= wdata[TLBIDX_NE_BIT];
                    end
                    CSR_TLBEHI: ehi_vppn <= wdata[TLBEHI_VPPN_LSB +: 19];
                    CSR_TLBELO0: begin
                        elo0_q <= elo_page(wdata);
                        elo0_g <= wdata[ELO_G_BIT];
                    end
                    CSR_TLBELO1: begin
                        elo1_q <= elo_page(wdata);
                        elo1_g <= wdata[ELO_G_BIT];
                    end
                    default: ;
                endcase
            end
            // search result lands in TLBIDX
            if (op == TLB_SRCH) begin
                idx_ne <= ~lookup_i.found;
                if (lookup_i.found) begin
                    idx_q <= lookup_i.index;
                end
            end
            if (op == TLB_FILL) begin
                fill_ptr <= fill_ptr + 1'b1;
            end
        end
    end

    always_comb begin
        csr_rdata_o = '0;
        case (csr_raddr_i)
            CSR_CRMD: begin
                csr_rdata_o[CRMD_DA_BIT]       = crmd_da;
                csr_rdata_o[CRMD_PLV_LSB +: 2] = crmd_plv;
            end
            CSR_ASID: csr_rdata_o[9:0] = asid_q;
            CSR_DMW0: csr_rdata_o = dmw0_q;
            CSR_DMW1: csr_rdata_o = dmw1_q;
            CSR_TLBIDX: begin
                csr_rdata_o[TLBIDX_IDX_LSB +: 4] = idx_q;
                csr_rdata_o[TLBIDX_PS_LSB +: 6]  = idx_ps;
                csr_rdata_o[TLBIDX_NE_BIT]       = idx_ne;
            end
            CSR_TLBEHI:  csr_rdata_o[TLBEHI_VPPN_LSB +: 19] = ehi_vppn;
            CSR_TLBELO0: csr_rdata_o = elo_word(elo0_q, elo0_g);
            CSR_TLBELO1: csr_rdata_o = elo_word(elo1_q, elo1_g);
            default:     csr_rdata_o = '0;
        endcase
    end

    assign ctx_o.direct = crmd_da;
    assign ctx_o.plv    = crmd_plv;
    assign ctx_o.asid   = asid_q;
    assign ctx_o.dmw0   = dmw0_q;
    assign ctx_o.dmw1   = dmw1_q;

    // entry image for TLBWR and TLBFILL
    assign tlb_we_o            = (op == TLB_WR) || (op == TLB_FILL);
    assign tlb_widx_o          = (op == TLB_FILL) ? fill_ptr : idx_q;
    assign tlb_wentry_o.exists = ~idx_ne;
    assign tlb_wentry_o.vppn   = ehi_vppn;
    assign tlb_wentry_o.asid   = asid_q;
    assign tlb_wentry_o.global = elo0_g & elo1_g;
    assign tlb_wentry_o.ps     = idx_ps;
    assign tlb_wentry_o.even   = elo0_q;
    assign tlb_wentry_o.odd    = elo1_q;

    assign srch_sel_o  = (op == TLB_SRCH);
    assign srch_vppn_o = ehi_vppn;

    assign inv_all_o   = (op == TLB_INV_ALL);
    assign inv_match_o = (op == TLB_INV_ASID_VA);
    assign inv_asid_o  = tlb_cmd_i.inv_asid;
    assign inv_vppn_o  = tlb_cmd_i.inv_vppn;

endmodule

// File: rtl/mmu_pkg.sv
package mmu_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [3:0]  csr_addr_t;
    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;
    typedef logic [5:0]  ps_t;
    typedef logic [3:0]  tlb_idx_t;

    localparam int  TLB_ENTRIES = 16;
    localparam ps_t PS_4K       = 6'd12;
    localparam ps_t PS_2M       = 6'd21;

    // register addresses on the software port
    localparam csr_addr_t CSR_CRMD    = 4'h0;
    localparam csr_addr_t CSR_ASID    = 4'h1;
    localparam csr_addr_t CSR_DMW0    = 4'h2;
    localparam csr_addr_t CSR_DMW1    = 4'h3;
    localparam csr_addr_t CSR_TLBIDX  = 4'h4;
    localparam csr_addr_t CSR_TLBEHI  = 4'h5;
    localparam csr_addr_t CSR_TLBELO0 = 4'h6;
    localparam csr_addr_t CSR_TLBELO1 = 4'h7;

    // field positions
    localparam int CRMD_PLV_LSB    = 0;
    localparam int CRMD_DA_BIT     = 3;
    localparam int DMW_PLV0_BIT    = 0;
    localparam int DMW_PLV3_BIT    = 3;
    localparam int DMW_MAT_LSB     = 4;
    localparam int DMW_PSEG_LSB    = 25;
    localparam int DMW_VSEG_LSB    = 29;
    localparam int TLBIDX_IDX_LSB  = 0;
    localparam int TLBIDX_PS_LSB   = 24;
    localparam int TLBIDX_NE_BIT   = 31;
    localparam int TLBEHI_VPPN_LSB = 13;
    localparam int ELO_V_BIT       = 0;
    localparam int ELO_D_BIT       = 1;
    localparam int ELO_PLV_LSB     = 2;
    localparam int ELO_MAT_LSB     = 4;
    localparam int ELO_G_BIT       = 6;
    localparam int ELO_PPN_LSB     = 8;

    typedef enum logic [1:0] {BYTE, HALF, WORD} size_e;

    typedef enum logic [2:0] {
        TLB_NONE, TLB_WR, TLB_FILL, TLB_SRCH, TLB_INV_ALL, TLB_INV_ASID_VA
    } tlb_op_e;

    typedef enum logic [2:0] {
        EXC_NONE, EXC_ADEM, EXC_ALE, EXC_TLBR, EXC_PIL, EXC_PIS, EXC_PPI, EXC_PME
    } excp_e;

    typedef struct packed {
        vaddr_t vaddr;
        logic   is_store;
        size_e  size;
    } mem_req_t;

    typedef struct packed {
        paddr_t paddr;
        logic   uncached;
        excp_e  excp;
    } mem_rsp_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        plv_t plv;
        mat_t mat;
        ppn_t ppn;
    } tlb_page_t;

    typedef struct packed {
        logic      exists;
        vppn_t     vppn;
        asid_t     asid;
        logic      global;
        ps_t       ps;
        tlb_page_t even;
        tlb_page_t odd;
    } tlb_entry_t;

    typedef struct packed {
        logic      found;
        tlb_idx_t  index;
        ps_t       ps;
        tlb_page_t page;
    } tlb_lookup_t;

    typedef struct packed {
        logic      direct;
        plv_t      plv;
        asid_t     asid;
        csr_data_t dmw0;
        csr_data_t dmw1;
    } trans_ctx_t;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        csr_data_t wdata;
    } csr_wr_t;

    typedef struct packed {
        tlb_op_e op;
        asid_t   inv_asid;
        vppn_t   inv_vppn;
    } tlb_cmd_t;

endpackage

// File: rtl/mmu_top.sv
`timescale 1ns/100ps

module mmu_top import mmu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  mem_req_t  req_i,
    output logic      rsp_valid_o,
    input  logic      rsp_ready_i,
    output mem_rsp_t  rsp_o,
    input  csr_wr_t   csr_wr_i,
    input  csr_addr_t csr_raddr_i,
    output csr_data_t csr_rdata_o,
    input  tlb_cmd_t  tlb_cmd_i
);

    trans_ctx_t  ctx;
    logic        tlb_we;
    tlb_idx_t    tlb_widx;
    tlb_entry_t  tlb_wentry;
    logic        srch_sel;
    vppn_t       csr_srch_vppn;
    vppn_t       at_srch_vppn;
    logic        at_srch_odd;
    asid_t       srch_asid;
    vppn_t       srch_vppn;
    logic        srch_odd;
    tlb_lookup_t lookup;
    logic        inv_all;
    logic        inv_match;
    asid_t       inv_asid;
    vppn_t       inv_vppn;

    // TLBSRCH borrows the search port for one cycle
    assign srch_vppn = srch_sel ? csr_srch_vppn : at_srch_vppn;
    assign srch_odd  = srch_sel ? 1'b0 : at_srch_odd;

    mmu_csr i_csr (
        .clk          (clk),
        .reset        (reset),
        .csr_wr_i     (csr_wr_i),
        .csr_raddr_i  (csr_raddr_i),
        .csr_rdata_o  (csr_rdata_o),
        .tlb_cmd_i    (tlb_cmd_i),
        .lookup_i     (lookup),
        .ctx_o        (ctx),
        .tlb_we_o     (tlb_we),
        .tlb_widx_o   (tlb_widx),
        .tlb_wentry_o (tlb_wentry),
        .srch_sel_o   (srch_sel),
        .srch_vppn_o  (csr_srch_vppn),
        .inv_all_o    (inv_all),
        .inv_match_o  (inv_match),
        .inv_asid_o   (inv_asid),
        .inv_vppn_o   (inv_vppn)
    );

    tlb_array i_tlb (
        .clk         (clk),
        .reset       (reset),
        .srch_vppn_i (srch_vppn),
        .srch_odd_i  (srch_odd),
        .srch_asid_i (srch_asid),
        .lookup_o    (lookup),
        .we_i        (tlb_we),
        .widx_i      (tlb_widx),
        .wentry_i    (tlb_wentry),
        .inv_all_i   (inv_all),
        .inv_match_i (inv_match),
        .inv_asid_i  (inv_asid),
        .inv_vppn_i  (inv_vppn)
    );

    addr_trans i_trans (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (flush_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o),
        .ctx_i       (ctx),
        .hold_i      (srch_sel),
        .srch_vppn_o (at_srch_vppn),
        .srch_odd_o  (at_srch_odd),
        .srch_asid_o (srch_asid),
        .lookup_i    (lookup)
    );

endmodule

// File: rtl/tlb_array.sv
`timescale 1ns/100ps

module tlb_array import mmu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  vppn_t       srch_vppn_i,
    input  logic        srch_odd_i,
    input  asid_t       srch_asid_i,
    output tlb_lookup_t lookup_o,
    input  logic        we_i,
    input  tlb_idx_t    widx_i,
    input  tlb_entry_t  wentry_i,
    input  logic        inv_all_i,
    input  logic        inv_match_i,
    input  asid_t       inv_asid_i,
    input  vppn_t       inv_vppn_i
);

    tlb_entry_t             entry_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] hit;
    logic [TLB_ENTRIES-1:0] inv_hit;

    // a 2M entry only compares address bits 31..22
    function automatic logic vppn_match(tlb_entry_t e, vppn_t vppn);
        if (e.ps == PS_2M) begin
            return e.vppn[18:9] == vppn[18:9];
        end
        return e.vppn == vppn;
    endfunction

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit[i] = entry_q[i].exists
                     && (entry_q[i].global || entry_q[i].asid == srch_asid_i)
                     && vppn_match(entry_q[i], srch_vppn_i);
            inv_hit[i] = !entry_q[i].global
                         && entry_q[i].asid == inv_asid_i
                         && vppn_match(entry_q[i], inv_vppn_i);
        end
    end

    // lowest matching index wins, scan from the top down
    always_comb begin
        logic odd_sel;
        lookup_o = '0;
        odd_sel  = 1'b0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                // half select is address bit 21 for 2M, bit 12 for 4K
                odd_sel        = (entry_q[i].ps == PS_2M) ? srch_vppn_i[8] : srch_odd_i;
                lookup_o.found = 1'b1;
                lookup_o.index = tlb_idx_t'(i);
                lookup_o.ps    = entry_q[i].ps;
                lookup_o.page  = odd_sel ? entry_q[i].odd : entry_q[i].even;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entry_q[i].exists <= 1'b0;
            end
        end else begin
            if (we_i) begin
                entry_q[widx_i] <= wentry_i;
            end
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                if (inv_all_i || (inv_match_i && inv_hit[i])) begin
                    entry_q[i].exists <= 1'b0;
                end
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mmu -f list.f -o tb_mmu_sim \
    && ./obj_dir/tb_mmu_sim 2>&1 | tee sim.log
grep -q "^TB PASSED$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: testbench/mmu_assert.sv
`timescale 1ns/100ps

module mmu_assert import mmu_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     flush_i,
    input logic     req_ready_o,
    input logic     rsp_valid_o,
    input logic     rsp_ready_i,
    input mem_rsp_t rsp_o
);

    int fail_count = 0;

    // stalled response keeps valid and payload
    rsp_hold: assert property (@(posedge clk) disable iff (reset || flush_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else begin
        fail_count++;
        $error("response changed while stalled");
    end

    // pipeline is empty for two cycles after reset
    no_early_rsp: assert property (@(posedge clk)
        $fell(reset) |-> !rsp_valid_o ##1 !rsp_valid_o)
    else begin
        fail_count++;
        $error("response valid too soon after reset");
    end

    ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> req_ready_o)
    else begin
        fail_count++;
        $error("request port not ready after reset");
    end

endmodule

bind mmu_top mmu_assert i_assert (
    .clk         (clk),
    .reset       (reset),
    .flush_i     (flush_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
);

// File: testbench/tb_mmu.sv
`timescale 1ns/100ps

module tb_mmu import mmu_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int MAX_WAIT   = 16;
    localparam int N_DIRECT   = 20;
    localparam int N_BURST    = 32;
    localparam int N_SINGLE   = 24;
    // worst case per streamed or single request plus register setup
    localparam int WATCHDOG_CYCLES = 8 + (N_DIRECT + N_BURST) * MAX_WAIT
                                     + N_SINGLE * 2 * MAX_WAIT + 200;

    logic      clk;
    logic      reset;
    logic      flush;
    logic      req_valid;
    logic      req_ready;
    mem_req_t  req;
    logic      rsp_valid;
    logic      rsp_ready;
    mem_rsp_t  rsp;
    csr_wr_t   csr_wr;
    csr_addr_t csr_raddr;
    csr_data_t csr_rdata;
    tlb_cmd_t  tlb_cmd;

    mmu_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (flush),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .rsp_o       (rsp),
        .csr_wr_i    (csr_wr),
        .csr_raddr_i (csr_raddr),
        .csr_rdata_o (csr_rdata),
        .tlb_cmd_i   (tlb_cmd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error("watchdog expired before the tests finished");
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "%s", what);
    endtask

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (expected !== actual) begin
            stop_on_error($sformatf("Mismatch in %s: expected %0h, actual %0h",
                                    name, expected, actual));
        end
    endtask

    function automatic csr_data_t elo_value(logic v, logic d, plv_t plv, mat_t mat,
                                            logic g, ppn_t ppn);
        csr_data_t w;
        w = '0;
        w[ELO_V_BIT]         = v;
        w[ELO_D_BIT]         = d;
        w[ELO_PLV_LSB +: 2]  = plv;
        w[ELO_MAT_LSB +: 2]  = mat;
        w[ELO_G_BIT]         = g;
        w[ELO_PPN_LSB +: 20] = ppn;
        return w;
    endfunction

    function automatic csr_data_t dmw_value(logic [2:0] vseg, logic [2:0] pseg,
                                            logic plv0, logic plv3, mat_t mat);
        csr_data_t w;
        w = '0;
        w[DMW_VSEG_LSB +: 3] = vseg;
        w[DMW_PSEG_LSB +: 3] = pseg;
        w[DMW_PLV0_BIT]      = plv0;
        w[DMW_PLV3_BIT]      = plv3;
        w[DMW_MAT_LSB +: 2]  = mat;
        return w;
    endfunction

    // page frame joined with the in-page offset
    function automatic paddr_t page_pa(ppn_t ppn, logic big, vaddr_t va);
        paddr_t base;
        base = {ppn, 12'h000};
        if (big) begin
            return {base[31:21], va[20:0]};
        end
        return {base[31:12], va[11:0]};
    endfunction

    task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
        csr_wr.we    = 1'b1;
        csr_wr.addr  = addr;
        csr_wr.wdata = data;
        @(negedge clk);
        csr_wr.we = 1'b0;
    endtask

    task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
        csr_raddr = addr;
        #1;
        data = csr_rdata;
        @(negedge clk);
    endtask

    task automatic tlb_command(input tlb_op_e op, input asid_t asid, input vppn_t vppn);
        tlb_cmd.op       = op;
        tlb_cmd.inv_asid = asid;
        tlb_cmd.inv_vppn = vppn;
        @(negedge clk);
        tlb_cmd.op = TLB_NONE;
    endtask

    task automatic load_entry(input tlb_op_e op, input tlb_idx_t idx, input ps_t ps,
                              input vaddr_t va, input csr_data_t elo0, input csr_data_t elo1);
        csr_data_t tlbidx;
        tlbidx = '0;
        tlbidx[TLBIDX_IDX_LSB +: 4] = idx;
        tlbidx[TLBIDX_PS_LSB +: 6]  = ps;
        csr_write(CSR_TLBIDX, tlbidx);
        csr_write(CSR_TLBEHI, va);
        csr_write(CSR_TLBELO0, elo0);
        csr_write(CSR_TLBELO1, elo1);
        tlb_command(op, '0, '0);
    endtask

    // one request with a full handshake on both sides
    task automatic translate(input string name, input vaddr_t va, input logic store,
                             input size_e size, input paddr_t exp_pa, input logic exp_unc,
                             input excp_e exp_excp);
        int   waited;
        logic accepted;
        req.vaddr    = va;
        req.is_store = store;
        req.size     = size;
        req_valid    = 1'b1;
        rsp_ready    = 1'b1;
        waited       = 0;
        accepted     = 1'b0;
        while (!accepted) begin
            #1;
            accepted = req_ready;
            @(negedge clk);
            waited++;
            if (!accepted && waited > MAX_WAIT) begin
                stop_on_error({name, ": request was never accepted"});
            end
        end
        req_valid = 1'b0;
        waited    = 0;
        #1;
        while (!rsp_valid) begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > MAX_WAIT) begin
                stop_on_error({name, ": no response arrived"});
            end
        end
        check_val({name, " excp"}, exp_excp, rsp.excp);
        if (exp_excp == EXC_NONE) begin
            check_val({name, " paddr"}, exp_pa, rsp.paddr);
            check_val({name, " uncached"}, exp_unc, rsp.uncached);
        end
        @(negedge clk);
    endtask

    // direct mode stream where the physical address echoes the virtual one
    task automatic run_stream(input string name, input int n, input bit random_ready);
        vaddr_t exp_q[$];
        int     acc_q[$];
        int     issued;
        int     received;
        int     cycle;
        int     lat;
        logic   accepted;
        logic   delivered;
        issued   = 0;
        received = 0;
        cycle    = 0;
        while (received < n) begin
            if (!req_valid && issued < n) begin
                req.vaddr    = $urandom() & 32'hffff_fffc;
                req.is_store = 1'($urandom() % 2);
                req.size     = WORD;
                req_valid    = 1'b1;
            end
            rsp_ready = random_ready ? 1'($urandom() % 2) : 1'b1;
            #1;
            accepted  = req_valid && req_ready;
            delivered = rsp_valid && rsp_ready;
            if (delivered) begin
                if (exp_q.size() == 0) begin
                    stop_on_error({name, ": response arrived with no request pending"});
                end
                check_val({name, " paddr"}, exp_q.pop_front(), rsp.paddr);
                check_val({name, " uncached"}, 0, rsp.uncached);
                check_val({name, " excp"}, EXC_NONE, rsp.excp);
                // edges from acceptance to the response register load
                lat = cycle - 1 - acc_q.pop_front();
                if (!random_ready) begin
                    check_val({name, " latency"}, 2, lat);
                end
                received++;
            end
            if (accepted) begin
                exp_q.push_back(req.vaddr);
                acc_q.push_back(cycle);
                issued++;
            end
            @(negedge clk);
            cycle++;
            if (accepted) begin
                req_valid = 1'b0;
            end
            if (cycle > n * MAX_WAIT) begin
                stop_on_error({name, ": stream did not complete in time"});
            end
        end
        rsp_ready = 1'b1;
    endtask

    task automatic direct_mode_run();
        csr_data_t d;
        csr_read(CSR_CRMD, d);
        check_val("crmd after reset", 32'h8, d);
        run_stream("direct", N_DIRECT, 1'b0);
    endtask

    task automatic window_mapping();
        // DMW0 0xa/0xb at PLV0 cached, DMW1 0x8/0x9 at PLV3 uncached
        csr_write(CSR_DMW0, dmw_value(3'h5, 3'h0, 1'b1, 1'b0, 2'd1));
        csr_write(CSR_DMW1, dmw_value(3'h4, 3'h1, 1'b0, 1'b1, 2'd0));
        csr_write(CSR_CRMD, 32'h0);
        translate("dmw0 plv0", 32'ha000_1234, 1'b0, WORD, 32'h0000_1234, 1'b0, EXC_NONE);
        translate("dmw1 at plv0", 32'h8000_4568, 1'b0, WORD, '0, 1'b0, EXC_TLBR);
        csr_write(CSR_CRMD, 32'h3);
        translate("dmw1 plv3", 32'h8000_4568, 1'b1, WORD, 32'h2000_4568, 1'b1, EXC_NONE);
        csr_write(CSR_CRMD, 32'h0);
    endtask

    task automatic tlb_page_mapping();
        csr_data_t d;
        csr_write(CSR_ASID, 32'd5);
        load_entry(TLB_WR, 4'd3, PS_4K, 32'h0040_2000,
                   elo_value(1'b1, 1'b1, 2'd0, 2'd1, 1'b0, 20'h12345),
                   elo_value(1'b1, 1'b1, 2'd0, 2'd0, 1'b0, 20'h54321));
        translate("4k even", 32'h0040_2abc, 1'b0, WORD,
                  page_pa(20'h12345, 1'b0, 32'h0040_2abc), 1'b0, EXC_NONE);
        translate("4k odd", 32'h0040_3de0, 1'b1, WORD,
                  page_pa(20'h54321, 1'b0, 32'h0040_3de0), 1'b1, EXC_NONE);
        load_entry(TLB_FILL, 4'd9, PS_2M, 32'h4000_0000,
                   elo_value(1'b1, 1'b1, 2'd0, 2'd1, 1'b0, 20'h00600),
                   elo_value(1'b1, 1'b1, 2'd0, 2'd1, 1'b0, 20'h00a00));
        translate("2m even", 32'h4001_2344, 1'b0, WORD,
                  page_pa(20'h00600, 1'b1, 32'h4001_2344), 1'b0, EXC_NONE);
        translate("2m odd", 32'h4021_2344, 1'b0, WORD,
                  page_pa(20'h00a00, 1'b1, 32'h4021_2344), 1'b0, EXC_NONE);
        // first fill goes to index 0
        tlb_command(TLB_SRCH, '0, '0);
        csr_read(CSR_TLBIDX, d);
        check_val("search fill index", 0, d[TLBIDX_IDX_LSB +: 4]);
        check_val("search fill found", 0, d[TLBIDX_NE_BIT]);
        csr_write(CSR_TLBEHI, 32'h7000_0000);
        tlb_command(TLB_SRCH, '0, '0);
        csr_read(CSR_TLBIDX, d);
        check_val("search miss", 1, d[TLBIDX_NE_BIT]);
    endtask

    task automatic exception_priority();
        // even page invalid, odd page valid but clean
        load_entry(TLB_WR, 4'd5, PS_4K, 32'h0080_0000,
                   elo_value(1'b0, 1'b0, 2'd0, 2'd1, 1'b0, 20'h11111),
                   elo_value(1'b1, 1'b0, 2'd0, 2'd1, 1'b0, 20'h22222));
        csr_write(CSR_CRMD, 32'h3);
        translate("adem over ale", 32'hc000_0002, 1'b0, WORD, '0, 1'b0, EXC_ADEM);
        translate("ppi", 32'h0080_1000, 1'b0, WORD, '0, 1'b0, EXC_PPI);
        translate("ppi over pme", 32'h0080_1000, 1'b1, WORD, '0, 1'b0, EXC_PPI);
        translate("pis over ppi", 32'h0080_0000, 1'b1, WORD, '0, 1'b0, EXC_PIS);
        csr_write(CSR_CRMD, 32'h0);
        translate("ale over tlbr", 32'h1000_0001, 1'b0, HALF, '0, 1'b0, EXC_ALE);
        translate("ale", 32'h0040_2abe, 1'b0, WORD, '0, 1'b0, EXC_ALE);
        translate("pil", 32'h0080_0000, 1'b0, WORD, '0, 1'b0, EXC_PIL);
        translate("pis", 32'h0080_0004, 1'b1, BYTE, '0, 1'b0, EXC_PIS);
        translate("pme", 32'h0080_1000, 1'b1, WORD, '0, 1'b0, EXC_PME);
        translate("clean load", 32'h0080_1008, 1'b0, WORD,
                  page_pa(20'h22222, 1'b0, 32'h0080_1008), 1'b0, EXC_NONE);
    endtask

    task automatic tlb_invalidation();
        load_entry(TLB_WR, 4'd7, PS_4K, 32'h00c0_0000,
                   elo_value(1'b1, 1'b1, 2'd0, 2'd1, 1'b1, 20'h33333),
                   elo_value(1'b1, 1'b1, 2'd0, 2'd1, 1'b1, 20'h44444));
        tlb_command(TLB_INV_ASID_VA, 10'd5, vppn_t'(32'h0040_2000 >> 13));
        translate("inv non-global", 32'h0040_2abc, 1'b0, WORD, '0, 1'b0, EXC_TLBR);
        tlb_command(TLB_INV_ASID_VA, 10'd5, vppn_t'(32'h00c0_0000 >> 13));
        translate("global kept", 32'h00c0_0120, 1'b0, WORD,
                  page_pa(20'h33333, 1'b0, 32'h00c0_0120), 1'b0, EXC_NONE);
        tlb_command(TLB_INV_ALL, '0, '0);
        translate("inv all 4k", 32'h00c0_0120, 1'b0, WORD, '0, 1'b0, EXC_TLBR);
        translate("inv all 2m", 32'h4001_2344, 1'b0, WORD, '0, 1'b0, EXC_TLBR);
    endtask

    task automatic backpressure_burst();
        csr_write(CSR_CRMD, 32'h8);
        run_stream("burst", N_BURST, 1'b1);
    endtask

    initial begin
        void'($urandom(802));
        reset     = 1'b1;
        flush     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        csr_wr    = '0;
        csr_raddr = '0;
        tlb_cmd   = '0;
        repeat (8) @(negedge clk);
        reset     = 1'b0;
        rsp_ready = 1'b1;
        direct_mode_run();
        window_mapping();
        tlb_page_mapping();
        exception_priority();
        tlb_invalidation();
        backpressure_burst();
        if (i_dut.i_assert.fail_count != 0) begin
            stop_on_error("bound assertions reported failures");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule
